// ==== include/gpio_defines.svh ====
`ifndef GPIO_DEFINES_SVH
`define GPIO_DEFINES_SVH

// ******************************
// bus widths
// ******************************
`define AXI_ADDR_W 16
`define AXI_DATA_W 32

// ******************************
// gpio block
// ******************************
`define GPIO_W           16
`define GPIO_SYNC_STAGES 2

// word aligned register offsets
`define GPIO_OFS_DATA_OUT   8'h00
`define GPIO_OFS_DIR        8'h04
`define GPIO_OFS_DATA_IN    8'h08
`define GPIO_OFS_IRQ_STATUS 8'h0C
`define GPIO_OFS_IRQ_ENABLE 8'h10

`endif

// ==== source/axi_lite_pkg.sv ====
`include "gpio_defines.svh"

package axi_lite_pkg;

   // response codes of the b and r channels
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_t;

   typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

   typedef logic [`AXI_DATA_W-1:0] axi_data_t;

   // one strobe bit per data byte
   typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;

endpackage

// ==== source/gpio_pkg.sv ====
`include "gpio_defines.svh"

package gpio_pkg;

   typedef logic [`GPIO_W-1:0] gpio_vec_t;

   // register index as seen on address bits [4:2]
   typedef enum logic [2:0] {
      REG_DATA_OUT   = 3'(`GPIO_OFS_DATA_OUT >> 2),
      REG_DIR        = 3'(`GPIO_OFS_DIR >> 2),
      REG_DATA_IN    = 3'(`GPIO_OFS_DATA_IN >> 2),
      REG_IRQ_STATUS = 3'(`GPIO_OFS_IRQ_STATUS >> 2),
      REG_IRQ_ENABLE = 3'(`GPIO_OFS_IRQ_ENABLE >> 2)
   } gpio_reg_e;

endpackage

// ==== source/axi_local_bridge.sv ====
`timescale 1ns/1ps

module axi_local_bridge (
   input  logic                    ACLK,
   input  logic                    ARESETN,
   // write address channel
   input  axi_lite_pkg::axi_addr_t s_axi_awaddr,
   input  logic [3:0]              s_axi_awcache,
   input  logic [2:0]              s_axi_awprot,
   input  logic                    s_axi_awvalid,
   output logic                    s_axi_awready,
   // write data channel
   input  axi_lite_pkg::axi_data_t s_axi_wdata,
   input  axi_lite_pkg::axi_strb_t s_axi_wstrb,
   input  logic                    s_axi_wvalid,
   output logic                    s_axi_wready,
   // write response channel
   output logic                    s_axi_bvalid,
   input  logic                    s_axi_bready,
   output axi_lite_pkg::axi_resp_t s_axi_bresp,
   // read address channel
   input  axi_lite_pkg::axi_addr_t s_axi_araddr,
   input  logic [3:0]              s_axi_arcache,
   input  logic [2:0]              s_axi_arprot,
   input  logic                    s_axi_arvalid,
   output logic                    s_axi_arready,
   // read data channel
   output axi_lite_pkg::axi_data_t s_axi_rdata,
   output axi_lite_pkg::axi_resp_t s_axi_rresp,
   output logic                    s_axi_rvalid,
   input  logic                    s_axi_rready,
   // local bus
   output logic                    local_cs,
   output logic                    local_rnw,
   output axi_lite_pkg::axi_addr_t local_addr,
   output axi_lite_pkg::axi_strb_t local_be,
   output axi_lite_pkg::axi_data_t local_wdata,
   input  logic                    local_ack,
   input  axi_lite_pkg::axi_data_t local_rdata
);

   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      WRITE  = 2'd1,
      WRITE2 = 2'd2,
      READ   = 2'd3
   } state_e;

   state_e                  state;
   state_e                  state_nxt;
   logic                    rnw_q;
   axi_lite_pkg::axi_addr_t addr_q;
   axi_lite_pkg::axi_strb_t be_q;
   axi_lite_pkg::axi_data_t wdata_q;
   logic                    aw_hs;
   logic                    w_hs;
   logic                    ar_hs;

   // cache and prot carry no meaning for this slave

   // ******************************
   // handshakes
   // ******************************
   assign s_axi_awready = (state == IDLE);
   // W may ride along with AW out of IDLE
   assign s_axi_wready  = (state == WRITE) || (state == IDLE && s_axi_awvalid);
   // a read waits while a write address is offered
   assign s_axi_arready = (state == IDLE) && !s_axi_awvalid;

   assign aw_hs = s_axi_awvalid && s_axi_awready;
   assign w_hs  = s_axi_wvalid && s_axi_wready;
   assign ar_hs = s_axi_arvalid && s_axi_arready;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (aw_hs) begin
               state_nxt = w_hs ? WRITE2 : WRITE;
            end else if (ar_hs) begin
               state_nxt = READ;
            end
         end
         WRITE: begin
            if (w_hs) begin
               state_nxt = WRITE2;
            end
         end
         WRITE2: begin
            if (local_ack && s_axi_bready) begin
               state_nxt = IDLE;
            end
         end
         READ: begin
            if (local_ack && s_axi_rready) begin
               state_nxt = IDLE;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         state <= IDLE;
         rnw_q <= 1'b0;
      end else begin
         state <= state_nxt;
         if (aw_hs) begin
            rnw_q <= 1'b0;
         end else if (ar_hs) begin
            rnw_q <= 1'b1;
         end
      end
   end

   // transfer fields
   always_ff @(posedge ACLK) begin
      if (aw_hs) begin
         addr_q <= s_axi_awaddr;
      end else if (ar_hs) begin
         addr_q <= s_axi_araddr;
      end
      if (w_hs) begin
         wdata_q <= s_axi_wdata;
         be_q    <= s_axi_wstrb;
      end
   end

   // ******************************
   // local bus and responses
   // ******************************
   assign local_cs    = (state == WRITE2) || (state == READ);
   assign local_rnw   = rnw_q;
   assign local_addr  = addr_q;
   assign local_be    = be_q;
   assign local_wdata = wdata_q;

   assign s_axi_bvalid = (state == WRITE2) && local_ack;
   assign s_axi_bresp  = axi_lite_pkg::OKAY;
   assign s_axi_rvalid = (state == READ) && local_ack;
   assign s_axi_rresp  = axi_lite_pkg::OKAY;
   assign s_axi_rdata  = (state == READ) ? local_rdata : '0;

endmodule

// ==== source/gpio_input_sync.sv ====
`timescale 1ns/1ps
`include "gpio_defines.svh"

module gpio_input_sync (
   input  logic                ACLK,
   input  logic                ARESETN,
   input  gpio_pkg::gpio_vec_t gpio_in,
   output gpio_pkg::gpio_vec_t gpio_sync,
   output gpio_pkg::gpio_vec_t gpio_rise
);

   // stage 0 takes the raw pins
   gpio_pkg::gpio_vec_t sync_q [`GPIO_SYNC_STAGES];
   gpio_pkg::gpio_vec_t hist_q;

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         for (int i = 0; i < `GPIO_SYNC_STAGES; i++) begin
            sync_q[i] <= '0;
         end
         hist_q <= '0;
      end else begin
         sync_q[0] <= gpio_in;
         for (int i = 1; i < `GPIO_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
         hist_q <= sync_q[`GPIO_SYNC_STAGES-1];
      end
   end

   assign gpio_sync = sync_q[`GPIO_SYNC_STAGES-1];

   // low last cycle, high now
   assign gpio_rise = gpio_sync & ~hist_q;

endmodule

// ==== source/gpio_regs.sv ====
`timescale 1ns/1ps
`include "gpio_defines.svh"

module gpio_regs (
   input  logic                    ACLK,
   input  logic                    ARESETN,
   input  logic                    local_cs,
   input  logic                    local_rnw,
   input  axi_lite_pkg::axi_addr_t local_addr,
   input  axi_lite_pkg::axi_strb_t local_be,
   input  axi_lite_pkg::axi_data_t local_wdata,
   output logic                    local_ack,
   output axi_lite_pkg::axi_data_t local_rdata,
   input  gpio_pkg::gpio_vec_t     gpio_sync,
   input  gpio_pkg::gpio_vec_t     gpio_rise,
   output gpio_pkg::gpio_vec_t     gpio_out,
   output gpio_pkg::gpio_vec_t     gpio_oe,
   output logic                    irq
);

   gpio_pkg::gpio_vec_t     data_out_q;
   gpio_pkg::gpio_vec_t     dir_q;
   gpio_pkg::gpio_vec_t     irq_status_q;
   gpio_pkg::gpio_vec_t     irq_enable_q;
   gpio_pkg::gpio_vec_t     irq_clr;
   gpio_pkg::gpio_reg_e     reg_idx;
   axi_lite_pkg::axi_data_t rd_val;
   logic                    addr_hit;
   logic                    access;
   logic                    wr_en;

   function automatic gpio_pkg::gpio_vec_t byte_merge(
      input gpio_pkg::gpio_vec_t     old_val,
      input axi_lite_pkg::axi_data_t wdata,
      input axi_lite_pkg::axi_strb_t be
   );
      gpio_pkg::gpio_vec_t result;
      result = old_val;
      for (int b = 0; b < `GPIO_W / 8; b++) begin
         if (be[b]) begin
            result[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return result;
   endfunction

   // ******************************
   // decode
   // ******************************
   assign reg_idx  = gpio_pkg::gpio_reg_e'(local_addr[4:2]);
   assign addr_hit = (local_addr[`AXI_ADDR_W-1:5] == '0);
   // first cycle of chip select, the one where ack rises
   assign access   = local_cs && !local_ack;
   assign wr_en    = access && !local_rnw && addr_hit;

   // write-one-to-clear mask
   assign irq_clr = (wr_en && reg_idx == gpio_pkg::REG_IRQ_STATUS) ?
                    byte_merge('0, local_wdata, local_be) : '0;

   always_comb begin
      rd_val = '0;
      if (addr_hit) begin
         case (reg_idx)
            gpio_pkg::REG_DATA_OUT:   rd_val = axi_lite_pkg::axi_data_t'(data_out_q);
            gpio_pkg::REG_DIR:        rd_val = axi_lite_pkg::axi_data_t'(dir_q);
            gpio_pkg::REG_DATA_IN:    rd_val = axi_lite_pkg::axi_data_t'(gpio_sync);
            gpio_pkg::REG_IRQ_STATUS: rd_val = axi_lite_pkg::axi_data_t'(irq_status_q);
            gpio_pkg::REG_IRQ_ENABLE: rd_val = axi_lite_pkg::axi_data_t'(irq_enable_q);
            default:                  rd_val = '0;
         endcase
      end
   end

   // ******************************
   // registers
   // ******************************
   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         local_ack    <= 1'b0;
         data_out_q   <= '0;
         dir_q        <= '0;
         irq_status_q <= '0;
         irq_enable_q <= '0;
         irq          <= 1'b0;
      end else begin
         local_ack <= local_cs;
         if (wr_en) begin
            case (reg_idx)
               gpio_pkg::REG_DATA_OUT:
                  data_out_q <= byte_merge(data_out_q, local_wdata, local_be);
               gpio_pkg::REG_DIR:
                  dir_q <= byte_merge(dir_q, local_wdata, local_be);
               gpio_pkg::REG_IRQ_ENABLE:
                  irq_enable_q <= byte_merge(irq_enable_q, local_wdata, local_be);
               default: begin
               end
            endcase
         end
         // new edges beat a clear in the same cycle
         irq_status_q <= (irq_status_q & ~irq_clr) | gpio_rise;
         irq          <= |(irq_status_q & irq_enable_q);
      end
   end

   // read data is captured once and held while chip select stays high
   always_ff @(posedge ACLK) begin
      if (access) begin
         local_rdata <= rd_val;
      end
   end

   assign gpio_out = data_out_q;
   assign gpio_oe  = dir_q;

endmodule

// ==== source/gpio_subsystem.sv ====
`timescale 1ns/1ps

module gpio_subsystem (
   input  logic                    ACLK,
   input  logic                    ARESETN,
   input  axi_lite_pkg::axi_addr_t s_axi_awaddr,
   input  logic [3:0]              s_axi_awcache,
   input  logic [2:0]              s_axi_awprot,
   input  logic                    s_axi_awvalid,
   output logic                    s_axi_awready,
   input  axi_lite_pkg::axi_data_t s_axi_wdata,
   input  axi_lite_pkg::axi_strb_t s_axi_wstrb,
   input  logic                    s_axi_wvalid,
   output logic                    s_axi_wready,
   output logic                    s_axi_bvalid,
   input  logic                    s_axi_bready,
   output axi_lite_pkg::axi_resp_t s_axi_bresp,
   input  axi_lite_pkg::axi_addr_t s_axi_araddr,
   input  logic [3:0]              s_axi_arcache,
   input  logic [2:0]              s_axi_arprot,
   input  logic                    s_axi_arvalid,
   output logic                    s_axi_arready,
   output axi_lite_pkg::axi_data_t s_axi_rdata,
   output axi_lite_pkg::axi_resp_t s_axi_rresp,
   output logic                    s_axi_rvalid,
   input  logic                    s_axi_rready,
   input  gpio_pkg::gpio_vec_t     gpio_in,
   output gpio_pkg::gpio_vec_t     gpio_out,
   output gpio_pkg::gpio_vec_t     gpio_oe,
   output logic                    irq
);

   logic                    local_cs;
   logic                    local_rnw;
   axi_lite_pkg::axi_addr_t local_addr;
   axi_lite_pkg::axi_strb_t local_be;
   axi_lite_pkg::axi_data_t local_wdata;
   logic                    local_ack;
   axi_lite_pkg::axi_data_t local_rdata;
   gpio_pkg::gpio_vec_t     gpio_sync;
   gpio_pkg::gpio_vec_t     gpio_rise;

   axi_local_bridge u_bridge (
      .ACLK          (ACLK),
      .ARESETN       (ARESETN),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awcache (s_axi_awcache),
      .s_axi_awprot  (s_axi_awprot),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arcache (s_axi_arcache),
      .s_axi_arprot  (s_axi_arprot),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .local_cs      (local_cs),
      .local_rnw     (local_rnw),
      .local_addr    (local_addr),
      .local_be      (local_be),
      .local_wdata   (local_wdata),
      .local_ack     (local_ack),
      .local_rdata   (local_rdata)
   );

   gpio_input_sync u_sync (
      .ACLK      (ACLK),
      .ARESETN   (ARESETN),
      .gpio_in   (gpio_in),
      .gpio_sync (gpio_sync),
      .gpio_rise (gpio_rise)
   );

   gpio_regs u_regs (
      .ACLK        (ACLK),
      .ARESETN     (ARESETN),
      .local_cs    (local_cs),
      .local_rnw   (local_rnw),
      .local_addr  (local_addr),
      .local_be    (local_be),
      .local_wdata (local_wdata),
      .local_ack   (local_ack),
      .local_rdata (local_rdata),
      .gpio_sync   (gpio_sync),
      .gpio_rise   (gpio_rise),
      .gpio_out    (gpio_out),
      .gpio_oe     (gpio_oe),
      .irq         (irq)
   );

endmodule

// ==== verification/gpio_checker.sv ====
`timescale 1ns/1ps

module gpio_checker (
   input  logic                    ACLK,
   input  logic                    ARESETN,
   input  logic                    s_axi_bvalid,
   input  logic                    s_axi_bready,
   input  axi_lite_pkg::axi_resp_t s_axi_bresp,
   input  logic                    s_axi_rvalid,
   input  logic                    s_axi_rready,
   input  axi_lite_pkg::axi_data_t s_axi_rdata,
   input  axi_lite_pkg::axi_resp_t s_axi_rresp,
   input  gpio_pkg::gpio_vec_t     gpio_out,
   input  gpio_pkg::gpio_vec_t     gpio_oe,
   input  logic                    irq,
   // expectations from the stimulus table
   input  axi_lite_pkg::axi_data_t exp_rdata,
   input  logic                    pin_check,
   input  gpio_pkg::gpio_vec_t     exp_out,
   input  gpio_pkg::gpio_vec_t     exp_oe,
   input  logic                    exp_irq,
   input  logic                    finished,
   input  int                      timeouts,
   output int                      errors
);

   int                      error_count = 0;
   logic                    b_held      = 1'b0;
   logic                    r_held      = 1'b0;
   logic                    reported    = 1'b0;
   axi_lite_pkg::axi_data_t rdata_q;

   assign errors = error_count;

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Error %s expected 0x%h got 0x%h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic protocol_error(input string what);
      $display("Protocol error: %s", what);
      error_count++;
   endtask

   // ******************************
   // sampled on every rising edge
   // ******************************
   always @(posedge ACLK) begin
      if (ARESETN) begin
         if (s_axi_bvalid) begin
            compare("s_axi_bresp", axi_lite_pkg::OKAY, s_axi_bresp);
         end
         if (s_axi_rvalid) begin
            compare("s_axi_rresp", axi_lite_pkg::OKAY, s_axi_rresp);
         end
         // a stalled response must stay put
         if (b_held && !s_axi_bvalid) begin
            protocol_error("bvalid dropped before bready was seen");
         end
         if (r_held && !s_axi_rvalid) begin
            protocol_error("rvalid dropped before rready was seen");
         end else if (r_held) begin
            compare("s_axi_rdata", rdata_q, s_axi_rdata);
         end
         if (s_axi_rvalid && s_axi_rready) begin
            compare("s_axi_rdata", exp_rdata, s_axi_rdata);
         end
         if (pin_check) begin
            compare("gpio_out", exp_out, gpio_out);
            compare("gpio_oe", exp_oe, gpio_oe);
            compare("irq", exp_irq, irq);
            compare("s_axi_bvalid", 1'b0, s_axi_bvalid);
            compare("s_axi_rvalid", 1'b0, s_axi_rvalid);
         end
      end
      b_held  <= ARESETN && s_axi_bvalid && !s_axi_bready;
      r_held  <= ARESETN && s_axi_rvalid && !s_axi_rready;
      rdata_q <= s_axi_rdata;
      if (finished && !reported) begin
         $display("Checker summary: %0d errors, %0d timeouts", error_count, timeouts);
         reported <= 1'b1;
      end
   end

endmodule

// ==== verification/tb_gpio_subsystem.sv ====
`timescale 1ns/1ps
`include "gpio_defines.svh"

module tb_gpio_subsystem;

   localparam int WAIT_LIMIT = 40;

   localparam axi_lite_pkg::axi_addr_t ADR_OUT  = `GPIO_OFS_DATA_OUT;
   localparam axi_lite_pkg::axi_addr_t ADR_DIR  = `GPIO_OFS_DIR;
   localparam axi_lite_pkg::axi_addr_t ADR_IN   = `GPIO_OFS_DATA_IN;
   localparam axi_lite_pkg::axi_addr_t ADR_STAT = `GPIO_OFS_IRQ_STATUS;
   localparam axi_lite_pkg::axi_addr_t ADR_EN   = `GPIO_OFS_IRQ_ENABLE;

   // RDIN reads DATA_IN against the pins, RPIN drives random pins,
   // WRRD offers a write and a read in the same cycle
   typedef enum logic [2:0] {
      OP_WR, OP_RD, OP_RDIN, OP_PINS,
      OP_RPIN, OP_WAIT, OP_WRRD
   } op_e;

   typedef struct {
      op_e                     op;
      axi_lite_pkg::axi_addr_t addr;
      axi_lite_pkg::axi_data_t data;
      axi_lite_pkg::axi_strb_t strb;
      axi_lite_pkg::axi_data_t exp_rd;
      gpio_pkg::gpio_vec_t     exp_out;
      gpio_pkg::gpio_vec_t     exp_oe;
      logic                    exp_irq;
   } step_t;

   logic                    ACLK = 1'b0;
   logic                    ARESETN;
   axi_lite_pkg::axi_addr_t s_axi_awaddr;
   logic [3:0]              s_axi_awcache;
   logic [2:0]              s_axi_awprot;
   logic                    s_axi_awvalid;
   logic                    s_axi_awready;
   axi_lite_pkg::axi_data_t s_axi_wdata;
   axi_lite_pkg::axi_strb_t s_axi_wstrb;
   logic                    s_axi_wvalid;
   logic                    s_axi_wready;
   logic                    s_axi_bvalid;
   logic                    s_axi_bready;
   axi_lite_pkg::axi_resp_t s_axi_bresp;
   axi_lite_pkg::axi_addr_t s_axi_araddr;
   logic [3:0]              s_axi_arcache;
   logic [2:0]              s_axi_arprot;
   logic                    s_axi_arvalid;
   logic                    s_axi_arready;
   axi_lite_pkg::axi_data_t s_axi_rdata;
   axi_lite_pkg::axi_resp_t s_axi_rresp;
   logic                    s_axi_rvalid;
   logic                    s_axi_rready;
   gpio_pkg::gpio_vec_t     gpio_in;
   gpio_pkg::gpio_vec_t     gpio_out;
   gpio_pkg::gpio_vec_t     gpio_oe;
   logic                    irq;

   axi_lite_pkg::axi_data_t exp_rdata = '0;
   gpio_pkg::gpio_vec_t     exp_out   = '0;
   gpio_pkg::gpio_vec_t     exp_oe    = '0;
   logic                    exp_irq   = 1'b0;
   logic                    pin_check = 1'b0;
   logic                    finished  = 1'b0;
   gpio_pkg::gpio_vec_t     pins      = '0;
   int                      timeout_count = 0;
   int                      error_count;
   step_t                   steps [$];

   always #2 ACLK = ~ACLK;

   gpio_subsystem u_dut (
      .ACLK          (ACLK),
      .ARESETN       (ARESETN),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awcache (s_axi_awcache),
      .s_axi_awprot  (s_axi_awprot),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arcache (s_axi_arcache),
      .s_axi_arprot  (s_axi_arprot),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .gpio_in       (gpio_in),
      .gpio_out      (gpio_out),
      .gpio_oe       (gpio_oe),
      .irq           (irq)
   );

   gpio_checker u_chk (
      .ACLK         (ACLK),
      .ARESETN      (ARESETN),
      .s_axi_bvalid (s_axi_bvalid),
      .s_axi_bready (s_axi_bready),
      .s_axi_bresp  (s_axi_bresp),
      .s_axi_rvalid (s_axi_rvalid),
      .s_axi_rready (s_axi_rready),
      .s_axi_rdata  (s_axi_rdata),
      .s_axi_rresp  (s_axi_rresp),
      .gpio_out     (gpio_out),
      .gpio_oe      (gpio_oe),
      .irq          (irq),
      .exp_rdata    (exp_rdata),
      .pin_check    (pin_check),
      .exp_out      (exp_out),
      .exp_oe       (exp_oe),
      .exp_irq      (exp_irq),
      .finished     (finished),
      .timeouts     (timeout_count),
      .errors       (error_count)
   );

   function automatic void add_step(op_e op, axi_lite_pkg::axi_addr_t addr,
                                    axi_lite_pkg::axi_data_t data,
                                    axi_lite_pkg::axi_strb_t strb,
                                    axi_lite_pkg::axi_data_t exp_rd,
                                    gpio_pkg::gpio_vec_t out, gpio_pkg::gpio_vec_t oe,
                                    logic irq_lvl);
      steps.push_back('{op, addr, data, strb, exp_rd, out, oe, irq_lvl});
   endfunction

   task automatic report_timeout(input string what);
      $display("Timeout: gave up waiting for %s", what);
      timeout_count++;
   endtask

   task automatic set_ready(input logic is_read, input logic value);
      if (is_read) begin
         s_axi_rready <= value;
      end else begin
         s_axi_bready <= value;
      end
   endtask

   // ******************************
   // AXI driver
   // ******************************
   task automatic send_write(input axi_lite_pkg::axi_addr_t addr,
                             input axi_lite_pkg::axi_data_t data,
                             input axi_lite_pkg::axi_strb_t strb);
      int   cycles;
      logic aw_done;
      logic w_done;
      cycles  = 0;
      aw_done = 1'b0;
      w_done  = 1'b0;
      s_axi_awaddr  <= addr;
      s_axi_awvalid <= 1'b1;
      s_axi_wdata   <= data;
      s_axi_wstrb   <= strb;
      s_axi_wvalid  <= 1'b1;
      while (!(aw_done && w_done) && cycles < WAIT_LIMIT) begin
         @(posedge ACLK);
         cycles++;
         if (s_axi_awvalid && s_axi_awready) begin
            aw_done = 1'b1;
            s_axi_awvalid <= 1'b0;
         end
         if (s_axi_wvalid && s_axi_wready) begin
            w_done = 1'b1;
            s_axi_wvalid <= 1'b0;
         end
      end
      if (!(aw_done && w_done)) begin
         s_axi_awvalid <= 1'b0;
         s_axi_wvalid  <= 1'b0;
         report_timeout("write address and data handshake");
      end
   endtask

   task automatic send_read(input axi_lite_pkg::axi_addr_t addr);
      int   cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      s_axi_araddr  <= addr;
      s_axi_arvalid <= 1'b1;
      while (!done && cycles < WAIT_LIMIT) begin
         @(posedge ACLK);
         cycles++;
         if (s_axi_arvalid && s_axi_arready) begin
            done = 1'b1;
         end
      end
      s_axi_arvalid <= 1'b0;
      if (!done) begin
         report_timeout("read address handshake");
      end
   endtask

   // ready is held back for a random 0 to 3 cycles once valid shows
   task automatic take_response(input logic is_read);
      int   cycles;
      int   stall;
      logic valid;
      logic done;
      cycles = 0;
      done   = 1'b0;
      stall  = $urandom % 4;
      set_ready(is_read, stall == 0);
      while (!done && cycles < WAIT_LIMIT) begin
         @(posedge ACLK);
         cycles++;
         valid = is_read ? s_axi_rvalid : s_axi_bvalid;
         if (valid && (is_read ? s_axi_rready : s_axi_bready)) begin
            done = 1'b1;
            set_ready(is_read, 1'b0);
         end else if (valid) begin
            stall--;
            if (stall <= 0) begin
               set_ready(is_read, 1'b1);
            end
         end
      end
      if (!done) begin
         set_ready(is_read, 1'b0);
         report_timeout(is_read ? "read response" : "write response");
      end
   endtask

   task automatic axi_write(input axi_lite_pkg::axi_addr_t addr,
                            input axi_lite_pkg::axi_data_t data,
                            input axi_lite_pkg::axi_strb_t strb);
      send_write(addr, data, strb);
      take_response(1'b0);
   endtask

   task automatic axi_read(input axi_lite_pkg::axi_addr_t addr,
                           input axi_lite_pkg::axi_data_t expected);
      exp_rdata <= expected;
      send_read(addr);
      take_response(1'b1);
   endtask

   // pins pass two sync stages and the edge logic before irq moves
   task automatic drive_pins(input gpio_pkg::gpio_vec_t value);
      gpio_in <= value;
      pins = value;
      repeat (4) @(posedge ACLK);
   endtask

   task automatic wait_irq(input logic level);
      int cycles;
      cycles = 0;
      while (irq !== level && cycles < WAIT_LIMIT) begin
         @(posedge ACLK);
         cycles++;
      end
      if (irq !== level) begin
         report_timeout("irq to reach the expected level");
      end
   endtask

   task automatic run_step(input step_t s);
      case (s.op)
         OP_WR:   axi_write(s.addr, s.data, s.strb);
         OP_RD:   axi_read(s.addr, s.exp_rd);
         OP_RDIN: axi_read(ADR_IN, axi_lite_pkg::axi_data_t'(pins));
         OP_PINS: drive_pins(s.data[`GPIO_W-1:0]);
         OP_RPIN: drive_pins(gpio_pkg::gpio_vec_t'($urandom));
         OP_WAIT: wait_irq(s.exp_irq);
         OP_WRRD: begin
            s_axi_araddr  <= s.addr;
            s_axi_arvalid <= 1'b1;
            axi_write(s.addr, s.data, s.strb);
            axi_read(s.addr, s.exp_rd);
         end
         default: begin
         end
      endcase
      exp_out   <= s.exp_out;
      exp_oe    <= s.exp_oe;
      exp_irq   <= s.exp_irq;
      pin_check <= 1'b1;
      @(posedge ACLK);
      pin_check <= 1'b0;
   endtask

   // ******************************
   // stimulus table
   // ******************************
   task automatic load_table();
      // reset values
      add_step(OP_WAIT, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h0000, 16'h0000, 1'b0);
      add_step(OP_RD, ADR_OUT, 32'h0, 4'h0, 32'h0, 16'h0000, 16'h0000, 1'b0);
      add_step(OP_RD, ADR_DIR, 32'h0, 4'h0, 32'h0, 16'h0000, 16'h0000, 1'b0);
      add_step(OP_RD, ADR_IN, 32'h0, 4'h0, 32'h0, 16'h0000, 16'h0000, 1'b0);
      add_step(OP_RD, ADR_STAT, 32'h0, 4'h0, 32'h0, 16'h0000, 16'h0000, 1'b0);
      add_step(OP_RD, ADR_EN, 32'h0, 4'h0, 32'h0, 16'h0000, 16'h0000, 1'b0);
      // byte strobes, lanes 2 and 3 lie above the 16 pins
      add_step(OP_WR, ADR_OUT, 32'h0000_a5c3, 4'hf, 32'h0, 16'ha5c3, 16'h0000, 1'b0);
      add_step(OP_WR, ADR_DIR, 32'h0000_00ff, 4'hf, 32'h0, 16'ha5c3, 16'h00ff, 1'b0);
      add_step(OP_WR, ADR_OUT, 32'h0000_1234, 4'h2, 32'h0, 16'h12c3, 16'h00ff, 1'b0);
      add_step(OP_WR, ADR_DIR, 32'hffff_5a00, 4'h2, 32'h0, 16'h12c3, 16'h5aff, 1'b0);
      add_step(OP_WR, ADR_OUT, 32'hffff_ff77, 4'h1, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WR, ADR_OUT, 32'hffff_ffff, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WR, ADR_DIR, 32'hffff_0000, 4'hc, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, ADR_OUT, 32'h0, 4'h0, 32'h1277, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, ADR_DIR, 32'h0, 4'h0, 32'h5aff, 16'h1277, 16'h5aff, 1'b0);
      // input pins, read-only DATA_IN, unmapped offsets
      add_step(OP_RPIN, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RDIN, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RPIN, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RDIN, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WR, ADR_IN, 32'h0000_ffff, 4'hf, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RDIN, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WR, 16'h0014, 32'hffff_ffff, 4'hf, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WR, 16'h0020, 32'hffff_ffff, 4'hf, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, 16'h0014, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, 16'h0020, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, ADR_OUT, 32'h0, 4'h0, 32'h1277, 16'h1277, 16'h5aff, 1'b0);
      // interrupt status and enable
      add_step(OP_PINS, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WR, ADR_STAT, 32'h0000_ffff, 4'hf, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, ADR_STAT, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WR, ADR_EN, 32'h0000_0005, 4'hf, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_PINS, 16'h0000, 32'h3, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b1);
      add_step(OP_WAIT, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b1);
      add_step(OP_RD, ADR_STAT, 32'h0, 4'h0, 32'h0003, 16'h1277, 16'h5aff, 1'b1);
      add_step(OP_WR, ADR_STAT, 32'h0000_0001, 4'hf, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WAIT, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, ADR_STAT, 32'h0, 4'h0, 32'h0002, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_PINS, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, ADR_STAT, 32'h0, 4'h0, 32'h0002, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_PINS, 16'h0000, 32'h4, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b1);
      add_step(OP_WAIT, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b1);
      add_step(OP_RD, ADR_STAT, 32'h0, 4'h0, 32'h0006, 16'h1277, 16'h5aff, 1'b1);
      add_step(OP_WR, ADR_EN, 32'h0000_0000, 4'h1, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WAIT, 16'h0000, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_WR, ADR_STAT, 32'h0000_ffff, 4'hf, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      add_step(OP_RD, ADR_STAT, 32'h0, 4'h0, 32'h0, 16'h1277, 16'h5aff, 1'b0);
      // write and read offered together
      add_step(OP_WRRD, ADR_OUT, 32'h0000_beef, 4'hf, 32'hbeef, 16'hbeef, 16'h5aff, 1'b0);
      add_step(OP_WRRD, ADR_DIR, 32'h0000_0f0f, 4'h1, 32'h5a0f, 16'hbeef, 16'h5a0f, 1'b0);
   endtask

   initial begin
      ARESETN       = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awcache = 4'h0;
      s_axi_awprot  = 3'h0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = '0;
      s_axi_arcache = 4'h0;
      s_axi_arprot  = 3'h0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      gpio_in       = '0;
      void'($urandom(32'hb675_5050));
      load_table();
      repeat (8) @(posedge ACLK);
      ARESETN <= 1'b1;
      @(posedge ACLK);
      foreach (steps[i]) begin
         run_step(steps[i]);
      end
      finished <= 1'b1;
      repeat (2) @(posedge ACLK);
      if (error_count == 0 && timeout_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+include
source/axi_lite_pkg.sv
source/gpio_pkg.sv
source/axi_local_bridge.sv
source/gpio_input_sync.sv
source/gpio_regs.sv
source/gpio_subsystem.sv
verification/gpio_checker.sv
verification/tb_gpio_subsystem.sv

// ==== Bender.yml ====
package:
  name: gpio_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/axi_lite_pkg.sv
      - source/gpio_pkg.sv
      - source/axi_local_bridge.sv
      - source/gpio_input_sync.sv
      - source/gpio_regs.sv
      - source/gpio_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/gpio_checker.sv
      - verification/tb_gpio_subsystem.sv
